//--- design/xlate_pkg.sv
// Data-side translation unit: Sv32 widths, PTE layout and payloads passed between its blocks
package xlate_pkg;

    localparam int ASID_W = 9;      // Sv32 ASID field
    localparam int PAGE_OFF_W = 12; // 4 KiB pages
    localparam int VPN_SEG_W = 10;  // VPN slice per walk level
    localparam int PT_IDX_W = 16;   // Widest page-table word index on the write port

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [19:0] ppn_t;
    typedef logic [ASID_W-1:0] asid_t;

    //////////////////////////////////////////////////
    // Sv32 page table entry, only low flag bits decoded
    typedef struct packed {
        ppn_t ppn;            // [31:12]
        logic [7:0] reserved; // D, A, U, X and RSW, ignored
        logic is_global;
        logic writable;
        logic readable;       // Clear at level 1 means pointer
        logic valid;
    } pte_t;

    typedef enum logic {
        OP_XLATE = 1'b0,
        OP_FENCE = 1'b1
    } op_kind_e;

    // Flush mode from {addr_only, asid_only}
    typedef struct packed {
        logic addr_only;
        logic asid_only;
        vaddr_t addr;
        asid_t asid;
    } fence_t;

    typedef struct packed {
        vaddr_t vaddr;
        logic rnw;      // 1 = load
        asid_t asid;
    } xlate_req_t;

    typedef struct packed {
        op_kind_e kind;
        xlate_req_t req;
        fence_t fence;
    } xlate_op_t;

    typedef struct packed {
        paddr_t paddr;
        logic fault;
    } xlate_rsp_t;

    // Walker result handed back to the TLB
    typedef struct packed {
        vaddr_t vaddr;
        ppn_t ppn;
        logic is_global;
        logic fault;
        asid_t asid;
    } fill_t;

    typedef struct packed {
        logic [PT_IDX_W-1:0] idx; // Word index into the page-table memory
        pte_t pte;
    } pt_wr_t;

endpackage

//--- design/lutram_1w_1r.sv
// LUT-style RAM with one synchronous write port and one asynchronous read port
`timescale 1ns/1ps

module lutram_1w_1r #(
    parameter type DATA_TYPE = logic,
    parameter int DEPTH = 32
) (
    input logic clk,
    input logic [$clog2(DEPTH)-1:0] waddr,
    input logic [$clog2(DEPTH)-1:0] raddr,
    input logic ram_write,
    input DATA_TYPE new_ram_data,
    output DATA_TYPE ram_data_out
);

    DATA_TYPE ram [DEPTH];

    always_ff @(posedge clk) begin
        if (ram_write)
            ram[waddr] <= new_ram_data;
    end

    // Read is combinational, new data visible after the write edge
    assign ram_data_out = ram[raddr];

endmodule

//--- design/xlate_op_merge.sv
// Operation merge: folds translation requests and fences into one registered op stream
`timescale 1ns/1ps

module xlate_op_merge (
    input logic clk,
    input logic rst,
    input logic req_valid,
    output logic req_ready,
    input xlate_pkg::xlate_req_t req,
    input logic fence_valid,
    output logic fence_ready,
    input xlate_pkg::fence_t fence,
    output logic op_valid,
    input logic op_ready,
    output xlate_pkg::xlate_op_t op
);
    import xlate_pkg::*;

    logic load;       // Slot empty or draining this cycle
    logic take_fence;
    logic take_req;

    assign load = ~op_valid | op_ready;
    assign fence_ready = load;                 // Fence wins arbitration
    assign req_ready = load & ~fence_valid;    // Request waits behind a pending fence
    assign take_fence = fence_valid & fence_ready;
    assign take_req = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (rst)
            op_valid <= 1'b0;
        else if (load)
            op_valid <= take_fence | take_req;
    end

    //////////////////////////////////////////////////
    // Payload, held while op_ready is low
    always_ff @(posedge clk) begin
        if (take_fence | take_req) begin
            op.kind <= take_fence ? OP_FENCE : OP_XLATE;
            op.req <= req;
            op.fence <= fence;
        end
    end

endmodule

//--- design/dtlb.sv
// Data TLB: set-associative lookup, random replacement, sequential fence flush, walker hand-off
`timescale 1ns/1ps

module dtlb #(
    parameter int TLB_WAYS = 2,
    parameter int TLB_DEPTH = 32
) (
    input logic clk,
    input logic rst,
    input logic translation_on,
    input logic op_valid,
    output logic op_ready,
    input xlate_pkg::xlate_op_t op,
    output logic walk_valid,
    input logic walk_ready,
    output xlate_pkg::xlate_req_t walk_req,
    input logic fill_valid,
    input xlate_pkg::fill_t fill,
    output logic res_valid,
    input logic res_ready,
    output xlate_pkg::xlate_rsp_t res
);
    import xlate_pkg::*;

    localparam int LINE_W = $clog2(TLB_DEPTH);
    localparam int TAG_W = 32 - PAGE_OFF_W - LINE_W;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        logic valid;
        logic is_global;
        asid_t asid;
        tag_t tag;
        ppn_t ppn;
    } entry_t;

    typedef enum logic [2:0] {S_IDLE, S_CMP, S_WALK, S_WAIT, S_RES, S_FLUSH} state_e;

    state_e state;
    xlate_req_t req_r;    // Translation in flight
    fence_t fence_r;      // Fence in flight, also selects clear mode
    xlate_rsp_t res_r;    // Result formed from a fill
    line_t flush_cnt;
    line_t raddr;
    line_t raddr_r;
    line_t waddr;
    logic clr_en;         // Clear stage, one cycle behind the fence line read
    logic accept;
    logic visit;
    tag_t cmp_tag;
    asid_t cmp_asid;
    entry_t rdata [TLB_WAYS];
    entry_t wdata;
    logic [TLB_WAYS-1:0] write;
    logic [TLB_WAYS-1:0] repl_way;
    logic [TLB_WAYS-1:0] tag_hit;
    logic [TLB_WAYS-1:0] asid_hit;  // Valid, non-global, same ASID
    logic [TLB_WAYS-1:0] glob_hit;  // Valid and global
    logic [TLB_WAYS-1:0] both_hit;
    ppn_t way_ppn [TLB_WAYS];
    ppn_t hit_ppn;
    logic hit;

    assign op_ready = (state == S_IDLE) & ~clr_en; // Wait out the last clear write
    assign accept = op_valid & op_ready;
    assign visit = (state == S_FLUSH) | (accept & (op.kind == OP_FENCE) & op.fence.addr_only);

    //////////////////////////////////////////////////
    // Lookup source
    always_comb begin
        if (state == S_FLUSH) begin
            raddr = flush_cnt;
            cmp_tag = fence_r.addr[31 -: TAG_W];
            cmp_asid = fence_r.asid;
        end else if (state != S_IDLE) begin
            raddr = req_r.vaddr[PAGE_OFF_W +: LINE_W];
            cmp_tag = req_r.vaddr[31 -: TAG_W];
            cmp_asid = req_r.asid;
        end else if (op.kind == OP_FENCE) begin
            raddr = op.fence.addr[PAGE_OFF_W +: LINE_W];
            cmp_tag = op.fence.addr[31 -: TAG_W];
            cmp_asid = op.fence.asid;
        end else begin
            raddr = op.req.vaddr[PAGE_OFF_W +: LINE_W];
            cmp_tag = op.req.vaddr[31 -: TAG_W];
            cmp_asid = op.req.asid;
        end
    end

    for (genvar i = 0; i < TLB_WAYS; i++) begin : g_way
        lutram_1w_1r #(.DATA_TYPE(entry_t), .DEPTH(TLB_DEPTH)) way_ram (
            .clk(clk),
            .waddr(waddr),
            .raddr(raddr),
            .ram_write(write[i]),
            .new_ram_data(wdata),
            .ram_data_out(rdata[i])
        );
    end

    // Compare register, reloaded every cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_WAYS; i++) begin
            tag_hit[i] <= rdata[i].tag == cmp_tag;
            asid_hit[i] <= rdata[i].valid & ~rdata[i].is_global & (rdata[i].asid == cmp_asid);
            glob_hit[i] <= rdata[i].valid & rdata[i].is_global;
            way_ppn[i] <= rdata[i].ppn;
        end
    end

    assign both_hit = tag_hit & (asid_hit | glob_hit);
    assign hit = |both_hit;

    always_comb begin
        hit_ppn = '0;
        for (int i = 0; i < TLB_WAYS; i++)
            hit_ppn = hit_ppn | (way_ppn[i] & {$bits(ppn_t){both_hit[i]}}); // One-hot AND-OR
    end

    // Free-running one-hot rotation picks the victim
    always_ff @(posedge clk) begin
        if (rst)
            repl_way <= TLB_WAYS'(1);
        else
            repl_way <= (repl_way << 1) | (repl_way >> (TLB_WAYS - 1));
    end

    //////////////////////////////////////////////////
    // Write port: fence clears or walker fills
    assign waddr = clr_en ? raddr_r : req_r.vaddr[PAGE_OFF_W +: LINE_W];
    assign wdata = '{valid: ~clr_en, is_global: fill.is_global, asid: fill.asid,
                     tag: fill.vaddr[31 -: TAG_W], ppn: fill.ppn};

    always_comb begin
        for (int i = 0; i < TLB_WAYS; i++) begin
            case ({clr_en, fence_r.addr_only, fence_r.asid_only})
                3'b100: write[i] = 1'b1;                     // Everything
                3'b101: write[i] = asid_hit[i];              // One space, globals kept
                3'b110: write[i] = tag_hit[i];               // One address, any space
                3'b111: write[i] = tag_hit[i] & asid_hit[i]; // Address within space
                default: write[i] = fill_valid & ~fill.fault & repl_way[i];
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Control FSM, reset starts a full flush
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_FLUSH;
            flush_cnt <= '0;
            fence_r <= '0;
            clr_en <= 1'b0;
        end else begin
            clr_en <= visit;
            case (state)
                S_IDLE: if (accept) begin
                    fence_r <= op.fence;
                    if (op.kind == OP_XLATE)
                        state <= S_CMP;
                    else if (!op.fence.addr_only)
                        state <= S_FLUSH;  // Address fence needs only the clear stage
                end
                S_CMP: begin
                    if (translation_on & ~hit)
                        state <= S_WALK;
                    else if (res_ready)
                        state <= S_IDLE;
                end
                S_WALK: if (walk_ready) state <= S_WAIT;
                S_WAIT: if (fill_valid) state <= S_RES;
                S_RES: if (res_ready) state <= S_IDLE;
                S_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == line_t'(TLB_DEPTH - 1))
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        raddr_r <= raddr;
        if (accept)
            req_r <= op.req;
        if (fill_valid) begin
            res_r.paddr <= {fill.ppn, req_r.vaddr[PAGE_OFF_W-1:0]};
            res_r.fault <= fill.fault;
        end
    end

    assign walk_valid = (state == S_WALK);
    assign walk_req = req_r;
    assign res_valid = (state == S_RES) | ((state == S_CMP) & (hit | ~translation_on));

    always_comb begin
        if (state == S_RES) begin
            res = res_r;
        end else begin
            res.fault = 1'b0;
            res.paddr = translation_on ? {hit_ppn, req_r.vaddr[PAGE_OFF_W-1:0]} : req_r.vaddr;
        end
    end

endmodule

//--- design/page_walker.sv
// Sv32 page-table walker: two-level walk over the page-table memory, returns a fill or a fault
`timescale 1ns/1ps

module page_walker #(
    parameter int PT_ADDR_W = 12
) (
    input logic clk,
    input logic rst,
    input xlate_pkg::ppn_t root_ppn,
    input logic walk_valid,
    output logic walk_ready,
    input xlate_pkg::xlate_req_t walk_req,
    output logic [PT_ADDR_W-1:0] pt_raddr,
    input xlate_pkg::pte_t pt_rdata,
    output logic fill_valid,
    output xlate_pkg::fill_t fill
);
    import xlate_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_L1, W_L0, W_DONE} walk_state_e;

    walk_state_e state;
    xlate_req_t req_r;
    ppn_t ppn_r;       // Table base during the walk, leaf page at the end
    logic glob_r;
    logic fault_r;
    logic [VPN_SEG_W-1:0] vpn_seg;
    logic [$bits(ppn_t)+VPN_SEG_W-1:0] word_addr;
    logic l1_fault;
    logic l0_fault;

    //////////////////////////////////////////////////
    // PTE address, page number wraps modulo memory size
    assign vpn_seg = (state == W_L1) ? req_r.vaddr[31 -: VPN_SEG_W]
                                     : req_r.vaddr[PAGE_OFF_W +: VPN_SEG_W];
    assign word_addr = {ppn_r, vpn_seg};
    assign pt_raddr = word_addr[PT_ADDR_W-1:0];

    // Level 1 must point onward, megapages unsupported
    assign l1_fault = ~pt_rdata.valid | pt_rdata.readable;

    // Level 0 must be a readable leaf, stores also need W
    assign l0_fault = ~pt_rdata.valid | ~pt_rdata.readable
                    | (~req_r.rnw & ~pt_rdata.writable);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: if (walk_valid) state <= W_L1;
                W_L1: state <= l1_fault ? W_DONE : W_L0;
                W_L0: state <= W_DONE;
                default: state <= W_IDLE;  // Done pulse lasts one cycle
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Walk datapath
    always_ff @(posedge clk) begin
        case (state)
            W_IDLE: begin
                req_r <= walk_req;  // Captured on the handshake
                ppn_r <= root_ppn;
                fault_r <= 1'b0;
            end
            W_L1: begin
                ppn_r <= pt_rdata.ppn;
                glob_r <= pt_rdata.is_global;
                fault_r <= l1_fault;
            end
            W_L0: begin
                ppn_r <= pt_rdata.ppn;
                glob_r <= glob_r | pt_rdata.is_global;  // Global pointer covers its leaves
                fault_r <= l0_fault;
            end
            default: begin
            end
        endcase
    end

    assign walk_ready = (state == W_IDLE);
    assign fill_valid = (state == W_DONE);
    assign fill = '{vaddr: req_r.vaddr, ppn: ppn_r, is_global: glob_r,
                    fault: fault_r, asid: req_r.asid};

endmodule

//--- design/xlate_rsp_buffer.sv
// Response buffer: two-entry FIFO between the TLB result and the requester
`timescale 1ns/1ps

module xlate_rsp_buffer (
    input logic clk,
    input logic rst,
    input logic res_valid,
    output logic res_ready,
    input xlate_pkg::xlate_rsp_t res,
    output logic rsp_valid,
    input logic rsp_ready,
    output xlate_pkg::xlate_rsp_t rsp
);
    import xlate_pkg::*;

    xlate_rsp_t mem [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] count;   // 0 to 2 held
    logic push;
    logic pop;

    assign res_ready = (count != 2'd2);   // Full rate while not full
    assign rsp_valid = (count != 2'd0);
    assign push = res_valid & res_ready;
    assign pop = rsp_valid & rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= res;
    end

    assign rsp = mem[rd_ptr];

endmodule

//--- design/xlate_top.sv
// Data-side Sv32 translation unit: op merge, TLB, walker, page-table memory and response buffer
`timescale 1ns/1ps

module xlate_top #(
    parameter int TLB_WAYS = 2,
    parameter int TLB_DEPTH = 32,
    parameter int PT_ADDR_W = 12   // At most PT_IDX_W
) (
    input logic clk,
    input logic rst,
    input logic translation_on,
    input xlate_pkg::ppn_t root_ppn,
    input logic req_valid,
    output logic req_ready,
    input xlate_pkg::xlate_req_t req,
    input logic fence_valid,
    output logic fence_ready,
    input xlate_pkg::fence_t fence,
    output logic rsp_valid,
    input logic rsp_ready,
    output xlate_pkg::xlate_rsp_t rsp,
    input logic pt_wr_valid,
    input xlate_pkg::pt_wr_t pt_wr
);
    import xlate_pkg::*;

    //////////////////////////////////////////////////
    // Internal links
    logic op_valid;
    logic op_ready;
    xlate_op_t op;
    logic walk_valid;
    logic walk_ready;
    xlate_req_t walk_req;
    logic fill_valid;
    fill_t fill;
    logic [PT_ADDR_W-1:0] pt_raddr;
    pte_t pt_rdata;
    logic res_valid;
    logic res_ready;
    xlate_rsp_t res;

    xlate_op_merge op_merge_i (.*);

    dtlb #(.TLB_WAYS(TLB_WAYS), .TLB_DEPTH(TLB_DEPTH)) dtlb_i (.*);

    page_walker #(.PT_ADDR_W(PT_ADDR_W)) page_walker_i (.*);

    // Page table, loaded over pt_wr
    lutram_1w_1r #(.DATA_TYPE(pte_t), .DEPTH(2 ** PT_ADDR_W)) page_table_i (
        .clk(clk),
        .waddr(pt_wr.idx[PT_ADDR_W-1:0]),
        .raddr(pt_raddr),
        .ram_write(pt_wr_valid),
        .new_ram_data(pt_wr.pte),
        .ram_data_out(pt_rdata)
    );

    xlate_rsp_buffer rsp_buffer_i (.*);

endmodule

//--- test/tb_xlate.sv
// Testbench for the Sv32 data translation unit, with a page-table shadow and TLB reference model
`timescale 1ns/1ps

module tb_xlate;
    import xlate_pkg::*;

    localparam int TLB_WAYS = 2;
    localparam int TLB_DEPTH = 32;
    localparam int PT_ADDR_W = 12;
    localparam int PT_WORDS = 2 ** PT_ADDR_W;
    localparam int TBL1 = 1024;               // Level 0 table at ppn 1
    localparam int NUM_PHASES = 6;
    localparam int WATCHDOG_CYCLES = 4000 * NUM_PHASES;
    localparam logic [31:0] SEED = 32'hfe9a186e;

    typedef struct packed {
        logic valid;
        logic glob;
        asid_t asid;
        logic [19:0] vpn;
        ppn_t ppn;
    } model_ent_t;                            // One live entry per TLB line in every test

    typedef struct packed {
        xlate_rsp_t rsp;
        logic chk_lat;                        // Idle hit or passthrough, 3 cycles
        logic [31:0] cyc;                     // Cycle of the request transfer
    } exp_t;

    logic clk = 1'b0;
    logic rst;
    logic translation_on;
    ppn_t root_ppn;
    logic req_valid;
    logic req_ready;
    xlate_req_t req;
    logic fence_valid;
    logic fence_ready;
    fence_t fence;
    logic rsp_valid;
    logic rsp_ready;
    xlate_rsp_t rsp;
    logic pt_wr_valid;
    pt_wr_t pt_wr;

    pte_t shadow [PT_WORDS];
    model_ent_t tlb_model [TLB_DEPTH];
    exp_t exp_q [$];
    logic [31:0] rng;
    logic [31:0] rdy_rng;
    logic [31:0] cyc = '0;
    logic bp_on;                              // Random rsp_ready
    logic hold_chk = 1'b0;
    xlate_rsp_t hold_rsp;
    string test_name;

    xlate_top #(.TLB_WAYS(TLB_WAYS), .TLB_DEPTH(TLB_DEPTH), .PT_ADDR_W(PT_ADDR_W)) xlate_top_i (.*);

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            r = {r[30:0], rng[0]};
        end
        return r;
    endfunction

    function automatic pte_t leaf_pte(ppn_t ppn, logic glob, logic wr);
        return '{ppn: ppn, reserved: 8'h00, is_global: glob, writable: wr,
                 readable: 1'b1, valid: 1'b1};
    endfunction

    function automatic pte_t ptr_pte(ppn_t ppn);
        return '{ppn: ppn, reserved: 8'h00, is_global: 1'b0, writable: 1'b0,
                 readable: 1'b0, valid: 1'b1};
    endfunction

    function automatic ppn_t map_ppn(int n, logic renewed);
        return (renewed ? 20'h90000 : 20'h40000) + 20'(n) * 20'h111;
    endfunction

    function automatic vaddr_t page_va(int l1, int l0, logic [11:0] off);
        return {10'(l1), 10'(l0), off};
    endfunction

    // Expected response, Sv32 walk over the shadow table
    function automatic xlate_rsp_t predict(xlate_req_t r);
        xlate_rsp_t e;
        logic [19:0] vpn;
        int set_idx;
        pte_t p1;
        pte_t p0;
        e.fault = 1'b0;
        e.paddr = r.vaddr;
        vpn = r.vaddr[31:12];
        set_idx = int'(vpn[4:0]);
        if (!translation_on)
            return e;
        if (tlb_model[set_idx].valid && tlb_model[set_idx].vpn == vpn &&
            (tlb_model[set_idx].glob || tlb_model[set_idx].asid == r.asid)) begin
            e.paddr = {tlb_model[set_idx].ppn, r.vaddr[11:0]};
            return e;
        end
        p1 = shadow[int'({root_ppn, vpn[19:10]} % PT_WORDS)];
        if (!p1.valid || p1.readable) begin  // Invalid or megapage
            e.fault = 1'b1;
            return e;
        end
        p0 = shadow[int'({p1.ppn, vpn[9:0]} % PT_WORDS)];
        e.fault = !p0.valid || !p0.readable || (!r.rnw && !p0.writable);
        e.paddr = {p0.ppn, r.vaddr[11:0]};
        if (!e.fault)
            tlb_model[set_idx] = '{valid: 1'b1, glob: p1.is_global | p0.is_global,
                                   asid: r.asid, vpn: vpn, ppn: p0.ppn};
        return e;
    endfunction

    function automatic void model_fence(fence_t f);
        logic addr_m;
        logic asid_m;
        for (int l = 0; l < TLB_DEPTH; l++) begin
            addr_m = tlb_model[l].vpn == f.addr[31:12];
            asid_m = !tlb_model[l].glob && tlb_model[l].asid == f.asid; // Globals survive
            case ({f.addr_only, f.asid_only})
                2'b00: tlb_model[l].valid = 1'b0;
                2'b01: if (asid_m) tlb_model[l].valid = 1'b0;
                2'b10: if (addr_m) tlb_model[l].valid = 1'b0;
                default: if (addr_m && asid_m) tlb_model[l].valid = 1'b0;
            endcase
        end
    endfunction

    //////////////////////////////////////////////////
    // Drivers, each starts and ends on a falling edge
    task automatic write_pte(int idx, pte_t p);
        pt_wr_valid = 1'b1;
        pt_wr = '{idx: PT_IDX_W'(idx), pte: p};
        shadow[idx] = p;
        @(negedge clk);
        pt_wr_valid = 1'b0;
    endtask

    task automatic send_req(vaddr_t va, logic rnw, asid_t asid, logic chk_lat);
        exp_t e;
        req_valid = 1'b1;
        req = '{vaddr: va, rnw: rnw, asid: asid};
        e.rsp = predict(req);
        e.chk_lat = chk_lat;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        e.cyc = cyc;
        exp_q.push_back(e);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_fence(logic addr_only, logic asid_only, vaddr_t va, asid_t asid);
        fence_valid = 1'b1;
        fence = '{addr_only: addr_only, asid_only: asid_only, addr: va, asid: asid};
        @(posedge clk);
        while (!fence_ready) @(posedge clk);
        model_fence(fence);
        @(negedge clk);
        fence_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_mismatch(string what, logic [63:0] exp_v, logic [63:0] act_v);
        $display("[ERROR] %s (%s): expected %h, actual %h", test_name, what, exp_v, act_v);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Response checker
    always @(posedge clk) begin
        exp_t e;
        cyc <= cyc + 1;
        hold_chk <= !rst && rsp_valid && !rsp_ready;
        hold_rsp <= rsp;
        if (!rst && hold_chk)
            assert (rsp_valid && rsp == hold_rsp)
            else fail_run("Response dropped or changed while stalled");
        if (!rst && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0)
                fail_run("Response arrived with no request outstanding");
            e = exp_q.pop_front();
            assert (rsp.fault == e.rsp.fault)
            else report_mismatch("fault", 64'(e.rsp.fault), 64'(rsp.fault));
            assert (e.rsp.fault || rsp.paddr == e.rsp.paddr)
            else report_mismatch("paddr", 64'(e.rsp.paddr), 64'(rsp.paddr));
            assert (!e.chk_lat || cyc - e.cyc == 3)
            else report_mismatch("latency", 64'd3, 64'(cyc - e.cyc));
        end
    end

    always @(negedge clk) begin
        rdy_rng = lfsr_step(rdy_rng);
        rsp_ready = bp_on ? rdy_rng[0] : 1'b1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a response never arrived", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        vaddr_t va;
        int n;
        rst = 1'b1;
        translation_on = 1'b0;
        root_ppn = '0;              // Root table at words 0 to 1023
        req_valid = 1'b0;
        req = '0;
        fence_valid = 1'b0;
        fence = '0;
        rsp_ready = 1'b1;
        pt_wr_valid = 1'b0;
        pt_wr = '0;
        bp_on = 1'b0;
        rng = SEED;
        rdy_rng = SEED;
        test_name = "setup";
        for (int i = 0; i < PT_WORDS; i++) shadow[i] = '0;
        for (int i = 0; i < TLB_DEPTH; i++) tlb_model[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        write_pte(1, ptr_pte(20'd1));
        write_pte(3, leaf_pte(20'h12345, 1'b0, 1'b1));  // Megapage, faults
        write_pte(4, '0);
        for (int i = 0; i < 32; i++) write_pte(TBL1 + i, leaf_pte(map_ppn(i, 1'b0), 1'b0, 1'b1));
        write_pte(TBL1 + 40, '0);
        write_pte(TBL1 + 41, leaf_pte(20'h0beef, 1'b0, 1'b0)); // Read-only
        write_pte(TBL1 + 42, ptr_pte(20'd2));                  // Pointer at level 0
        write_pte(TBL1 + 50, leaf_pte(20'h0a050, 1'b1, 1'b1)); // Global, line 18

        test_name = "passthrough";
        for (int k = 0; k < 16; k++) begin
            va = rand_bits(32);
            send_req(va, 1'(rand_bits(1)), asid_t'(rand_bits(9)), 1'b1);
            drain();
        end

        test_name = "walk_then_hit";
        translation_on = 1'b1;
        send_fence(1'b0, 1'b0, '0, '0);
        for (n = 10; n < 18; n++) begin
            va = page_va(1, n, 12'(rand_bits(12)));
            send_req(va, 1'b1, 9'd1, 1'b0);
            drain();
            send_req({va[31:12], 12'(rand_bits(12))}, 1'b0, 9'd1, 1'b1);
            drain();
        end

        test_name = "faults";
        send_fence(1'b0, 1'b0, '0, '0);
        send_req(page_va(4, 0, 12'h010), 1'b1, 9'd1, 1'b0);
        send_req(page_va(1, 40, 12'h020), 1'b1, 9'd1, 1'b0);
        send_req(page_va(1, 41, 12'h030), 1'b0, 9'd1, 1'b0); // Store before the load fills
        send_req(page_va(1, 41, 12'h034), 1'b1, 9'd1, 1'b0);
        send_req(page_va(3, 0, 12'h040), 1'b1, 9'd1, 1'b0);
        send_req(page_va(1, 42, 12'h050), 1'b1, 9'd1, 1'b0);
        drain();

        test_name = "asid_global";
        send_fence(1'b0, 1'b0, '0, '0);
        send_req(page_va(1, 5, 12'h100), 1'b1, 9'd1, 1'b0);
        drain();
        write_pte(TBL1 + 5, leaf_pte(map_ppn(5, 1'b1), 1'b0, 1'b1));
        send_req(page_va(1, 5, 12'h104), 1'b1, 9'd1, 1'b1);  // Old mapping, hit
        send_req(page_va(1, 5, 12'h108), 1'b1, 9'd2, 1'b0);  // Other space walks anew
        send_req(page_va(1, 5, 12'h10c), 1'b1, 9'd2, 1'b0);
        send_req(page_va(1, 50, 12'h200), 1'b1, 9'd3, 1'b0);
        drain();
        write_pte(TBL1 + 50, leaf_pte(20'h0a999, 1'b1, 1'b1));
        send_req(page_va(1, 50, 12'h204), 1'b1, 9'd4, 1'b0); // Global hit across ASIDs
        drain();

        test_name = "fences";
        send_fence(1'b0, 1'b0, '0, '0);
        send_req(page_va(1, 7, 12'h300), 1'b1, 9'd1, 1'b0);
        send_req(page_va(1, 9, 12'h304), 1'b1, 9'd2, 1'b0);
        send_req(page_va(1, 50, 12'h308), 1'b1, 9'd1, 1'b0);
        drain();
        write_pte(TBL1 + 7, leaf_pte(map_ppn(7, 1'b1), 1'b0, 1'b1));
        write_pte(TBL1 + 9, leaf_pte(map_ppn(9, 1'b1), 1'b0, 1'b1));
        write_pte(TBL1 + 50, leaf_pte(20'h0a777, 1'b1, 1'b1));
        send_fence(1'b0, 1'b1, '0, 9'd1);                    // ASID 1 only
        send_req(page_va(1, 7, 12'h310), 1'b1, 9'd1, 1'b0);
        send_req(page_va(1, 9, 12'h314), 1'b1, 9'd2, 1'b0);
        send_req(page_va(1, 50, 12'h318), 1'b1, 9'd1, 1'b0);
        send_fence(1'b1, 1'b0, page_va(1, 9, 12'h000), '0);  // One address
        send_req(page_va(1, 9, 12'h320), 1'b1, 9'd2, 1'b0);
        send_req(page_va(1, 50, 12'h324), 1'b1, 9'd2, 1'b0);
        send_fence(1'b1, 1'b1, page_va(1, 50, 12'h000), 9'd1);
        send_req(page_va(1, 50, 12'h328), 1'b1, 9'd1, 1'b0);
        send_fence(1'b0, 1'b0, '0, '0);
        send_req(page_va(1, 50, 12'h32c), 1'b1, 9'd1, 1'b0);
        drain();

        test_name = "back_pressure";
        send_fence(1'b0, 1'b0, '0, '0);
        bp_on = 1'b1;
        for (int k = 0; k < 64; k++) begin
            n = int'(rand_bits(5));
            va = page_va(1, n, 12'(rand_bits(12)));
            send_req(va, 1'(rand_bits(1)), asid_t'(rand_bits(9)), 1'b0);
        end
        drain();
        bp_on = 1'b0;

        if (exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d responses still outstanding", exp_q.size());
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

//--- files.f
design/xlate_pkg.sv
design/lutram_1w_1r.sv
design/xlate_op_merge.sv
design/dtlb.sv
design/page_walker.sv
design/xlate_rsp_buffer.sv
design/xlate_top.sv
test/tb_xlate.sv

//--- Bender.yml
package:
  name: xlate

sources:
  - files:
      - design/xlate_pkg.sv
      - design/lutram_1w_1r.sv
      - design/xlate_op_merge.sv
      - design/dtlb.sv
      - design/page_walker.sv
      - design/xlate_rsp_buffer.sv
      - design/xlate_top.sv
  - target: test
    files:
      - test/tb_xlate.sv
